// File: hdl/mbxPkg.sv
package mbxPkg;

  //////////////////////////////////////////////////
  // Line geometry
  //////////////////////////////////////////////////
  localparam int mbWords = 4;
  localparam int wordIdxW = 2;
  localparam int wordW = 36;

  typedef logic [wordIdxW-1:0] wordIdx_t;
  typedef logic [mbWords-1:0] wordMask_t;
  typedef logic [wordW-1:0] word_t;

  // Cache cycle opcodes
  typedef enum logic [2:0] {
    cycIdle,
    cycWriteback,
    cycOneWordWr,
    cycCoreRead,
    cycOneWordRd
  } cycle_e;

  typedef enum logic {
    xferIdle,
    xferLoad
  } xferState_e;

  //////////////////////////////////////////////////
  // Buses between the parts
  //////////////////////////////////////////////////
  typedef struct packed {
    logic start;
    cycle_e cyc;
    wordIdx_t wordAdr;
    wordMask_t wordVal;
  } cshReq_t;

  typedef struct packed {
    logic load;
    wordIdx_t idx;
    word_t data;
  } mbLoad_t;

  typedef struct packed {
    logic any;
    wordIdx_t sel;
    word_t data;
  } mbHead_t;

  typedef struct packed {
    logic wrRq;
    logic rdRq;
    wordIdx_t wordSel;
    wordMask_t rqMask;
    word_t data;
  } memPort_t;

  // Index of the lowest set bit, zero when the mask is empty
  function automatic wordIdx_t lowestIdx(input wordMask_t m);
    wordIdx_t idx;
    idx = '0;
    for (int k = mbWords - 1; k >= 0; k--) begin
      if (m[k]) begin
        idx = wordIdx_t'(k);
      end
    end
    return idx;
  endfunction

endpackage

// File: hdl/cacheToMbSeq.sv
`timescale 1ns/1ps

module cacheToMbSeq (
  input  logic             clk,
  input  logic             rstN,
  input  mbxPkg::cshReq_t  cshReq,
  input  mbxPkg::word_t    cacheData,
  output mbxPkg::wordIdx_t cacheWordIdx,
  output mbxPkg::mbLoad_t  mbLoad,
  output logic             xferActive
);

  mbxPkg::xferState_e state;
  mbxPkg::wordIdx_t cnt;
  mbxPkg::wordIdx_t lastIdx;
  logic isWriteback;
  logic isOneWordWr;
  logic startWr;

  //////////////////////////////////////////////////
  // Cycle decode
  //////////////////////////////////////////////////
  assign isWriteback = cshReq.cyc == mbxPkg::cycWriteback;
  assign isOneWordWr = cshReq.cyc == mbxPkg::cycOneWordWr;

  // Reads and idle cycles never leave xferIdle
  assign startWr = cshReq.start && (state == mbxPkg::xferIdle) &&
                   (isWriteback || isOneWordWr);

  //////////////////////////////////////////////////
  // Word stepping
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= mbxPkg::xferIdle;
      cnt     <= '0;
      lastIdx <= '0;
    end else begin
      unique case (state)
        mbxPkg::xferIdle: begin
          if (startWr) begin
            state <= mbxPkg::xferLoad;
            if (isWriteback) begin
              // Whole line, word 0 upward
              cnt     <= '0;
              lastIdx <= mbxPkg::wordIdx_t'(mbxPkg::mbWords - 1);
            end else begin
              cnt     <= cshReq.wordAdr;
              lastIdx <= cshReq.wordAdr;
            end
          end
        end
        mbxPkg::xferLoad: begin
          if (cnt == lastIdx) begin
            state <= mbxPkg::xferIdle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= mbxPkg::xferIdle;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Cache read and buffer load
  //////////////////////////////////////////////////
  assign xferActive   = state == mbxPkg::xferLoad;
  assign cacheWordIdx = cnt;

  // Cache answers in the same cycle, so data goes straight to the buffer
  always_comb begin
    mbLoad.load = xferActive;
    mbLoad.idx  = cnt;
    mbLoad.data = cacheData;
  end

endmodule

// File: hdl/mbWordTracker.sv
`timescale 1ns/1ps

module mbWordTracker (
  input  logic            clk,
  input  logic            rstN,
  input  mbxPkg::mbLoad_t mbLoad,
  input  logic            wrAck,
  output mbxPkg::mbHead_t head
);

  mbxPkg::word_t wordBuf [mbxPkg::mbWords];
  mbxPkg::wordMask_t pend;
  mbxPkg::wordMask_t pendNext;
  mbxPkg::wordIdx_t lowSel;
  mbxPkg::wordIdx_t heldSel;
  mbxPkg::wordIdx_t curSel;
  logic hold;
  logic anyPend;

  //////////////////////////////////////////////////
  // Buffer words
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (mbLoad.load) begin
      wordBuf[mbLoad.idx] <= mbLoad.data;
    end
  end

  //////////////////////////////////////////////////
  // Pending write bits
  //////////////////////////////////////////////////
  assign anyPend = |pend;

  always_comb begin
    pendNext = pend;
    // Ack retires the word shown this cycle
    if (wrAck) begin
      pendNext[curSel] = 1'b0;
    end
    if (mbLoad.load) begin
      pendNext[mbLoad.idx] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pend <= '0;
    end else begin
      pend <= pendNext;
    end
  end

  //////////////////////////////////////////////////
  // Select with hold
  //////////////////////////////////////////////////
  assign lowSel = mbxPkg::lowestIdx(pend);

  // Once offered, a word stays selected until memory takes it
  assign curSel = hold ? heldSel : lowSel;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hold    <= 1'b0;
      heldSel <= '0;
    end else begin
      hold    <= anyPend && !wrAck;
      heldSel <= curSel;
    end
  end

  always_comb begin
    head.any  = anyPend;
    head.sel  = curSel;
    head.data = wordBuf[curSel];
  end

endmodule

// File: hdl/memReqCtl.sv
`timescale 1ns/1ps

module memReqCtl (
  input  logic             clk,
  input  logic             rstN,
  input  mbxPkg::cshReq_t  cshReq,
  input  mbxPkg::mbHead_t  head,
  input  logic             xferActive,
  input  logic             memAck,
  output logic             wrAck,
  output mbxPkg::memPort_t mem,
  output logic             busy
);

  mbxPkg::wordMask_t rqMask;
  mbxPkg::wordMask_t rdBit;
  mbxPkg::wordIdx_t rdSel;
  logic rdRq;

  //////////////////////////////////////////////////
  // Read word mask
  //////////////////////////////////////////////////
  assign rdSel = mbxPkg::lowestIdx(rqMask);
  assign rdBit = mbxPkg::wordMask_t'(1) << rdSel;
  assign rdRq  = |rqMask;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rqMask <= '0;
    end else if (cshReq.start && !busy) begin
      unique case (cshReq.cyc)
        // Fetch only what the cache lacks
        mbxPkg::cycCoreRead: begin
          rqMask <= ~cshReq.wordVal;
        end
        mbxPkg::cycOneWordRd: begin
          rqMask <= mbxPkg::wordMask_t'(1) << cshReq.wordAdr;
        end
        default: begin
          rqMask <= rqMask;
        end
      endcase
    end else if (memAck && rdRq) begin
      rqMask <= rqMask & ~rdBit;
    end
  end

  //////////////////////////////////////////////////
  // Memory side
  //////////////////////////////////////////////////
  assign wrAck = memAck && head.any;

  always_comb begin
    mem.wrRq   = head.any;
    mem.rdRq   = rdRq;
    // Reads and writes never overlap
    mem.wordSel = rdRq ? rdSel : head.sel;
    mem.rqMask = rqMask;
    mem.data   = head.data;
  end

  assign busy = xferActive || head.any || rdRq;

endmodule

// File: hdl/mbx.sv
`timescale 1ns/1ps

module mbx (
  input  logic             clk,
  input  logic             rstN,
  input  mbxPkg::cshReq_t  cshReq,
  input  mbxPkg::word_t    cacheData,
  input  logic             memAck,
  output mbxPkg::wordIdx_t cacheWordIdx,
  output mbxPkg::memPort_t mem,
  output logic             busy
);

  mbxPkg::mbLoad_t mbLoad;
  mbxPkg::mbHead_t head;
  logic wrAck;
  logic xferActive;

  //////////////////////////////////////////////////
  // Cache to buffer
  //////////////////////////////////////////////////
  cacheToMbSeq iSeq (
    .clk          (clk),
    .rstN         (rstN),
    .cshReq       (cshReq),
    .cacheData    (cacheData),
    .cacheWordIdx (cacheWordIdx),
    .mbLoad       (mbLoad),
    .xferActive   (xferActive)
  );

  //////////////////////////////////////////////////
  // Buffer words and write selection
  //////////////////////////////////////////////////
  mbWordTracker iTracker (
    .clk    (clk),
    .rstN   (rstN),
    .mbLoad (mbLoad),
    .wrAck  (wrAck),
    .head   (head)
  );

  //////////////////////////////////////////////////
  // Memory requests
  //////////////////////////////////////////////////
  memReqCtl iReqCtl (
    .clk        (clk),
    .rstN       (rstN),
    .cshReq     (cshReq),
    .head       (head),
    .xferActive (xferActive),
    .memAck     (memAck),
    .wrAck      (wrAck),
    .mem        (mem),
    .busy       (busy)
  );

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int periodNs = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(periodNs / 2) clk = ~clk;
    end
  end

endmodule

// File: tb/mbxTb.sv
`timescale 1ns/1ps

module mbxTb;

  localparam int periodNs = 100;
  localparam int driveDly = 5;
  localparam int resetCycles = 16;
  localparam int nOps = 48;
  // Four loads and four acks with up to three idle cycles before each ack
  localparam int opCycles = 40;
  localparam int ageMax = 1000;
  localparam logic [31:0] rngSeed = 32'h4193;

  logic clk;
  logic rstN;
  mbxPkg::cshReq_t cshReq;
  mbxPkg::word_t cacheData;
  logic memAck;
  mbxPkg::wordIdx_t cacheWordIdx;
  mbxPkg::memPort_t mem;
  logic busy;

  mbxPkg::word_t line [mbxPkg::mbWords];
  logic [31:0] stimRng;
  logic [31:0] ackRng;
  int ackWait;
  int errCnt = 0;

  // Reference state stepped once per clock
  logic seenStart;
  int age;
  mbxPkg::cycle_e curCyc;
  mbxPkg::wordIdx_t curAdr;
  mbxPkg::wordMask_t curVal;
  mbxPkg::wordMask_t expWrPend;
  mbxPkg::wordMask_t expRdMask;
  mbxPkg::wordMask_t wrLoad;
  mbxPkg::wordIdx_t wbIdx;
  mbxPkg::wordIdx_t ackIdx;
  int expAcks;
  int ackCnt;
  int totalAcks;

  tbClock #(.periodNs(periodNs)) iClk (.clk(clk));

  mbx i_dut (
    .clk          (clk),
    .rstN         (rstN),
    .cshReq       (cshReq),
    .cacheData    (cacheData),
    .memAck       (memAck),
    .cacheWordIdx (cacheWordIdx),
    .mem          (mem),
    .busy         (busy)
  );

  // Cache line answers in the same cycle
  assign cacheData = line[cacheWordIdx];

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic mbxPkg::wordIdx_t firstSet(input mbxPkg::wordMask_t m);
    if (m[0]) return 2'd0;
    if (m[1]) return 2'd1;
    if (m[2]) return 2'd2;
    return 2'd3;
  endfunction

  function automatic int popCount(input mbxPkg::wordMask_t m);
    int n;
    n = 0;
    for (int k = 0; k < mbxPkg::mbWords; k++) begin
      n += int'(m[k]);
    end
    return n;
  endfunction

  task automatic flagError(input string msg);
    errCnt++;
    $display("MISMATCH @%0t: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  assign wbIdx  = mbxPkg::wordIdx_t'(age - 1);
  assign ackIdx = mbxPkg::wordIdx_t'(ackCnt);

  always_comb begin
    wrLoad = '0;
    if (curCyc == mbxPkg::cycWriteback && age >= 1 && age <= 4) begin
      wrLoad = mbxPkg::wordMask_t'(1) << wbIdx;
    end
    if (curCyc == mbxPkg::cycOneWordWr && age == 1) begin
      wrLoad = mbxPkg::wordMask_t'(1) << curAdr;
    end
  end

  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      seenStart <= 1'b0;
      age       <= 0;
      curCyc    <= mbxPkg::cycIdle;
      curAdr    <= '0;
      curVal    <= '0;
      expWrPend <= '0;
      expRdMask <= '0;
      expAcks   <= 0;
      ackCnt    <= 0;
      totalAcks <= 0;
    end else begin
      if (memAck) begin
        totalAcks <= totalAcks + 1;
      end
      // An ack retires the lowest loaded word
      expWrPend <= (memAck ? expWrPend & (expWrPend - 4'd1) : expWrPend) | wrLoad;
      if (cshReq.start) begin
        seenStart <= 1'b1;
        age       <= 1;
        curCyc    <= cshReq.cyc;
        curAdr    <= cshReq.wordAdr;
        curVal    <= cshReq.wordVal;
        ackCnt    <= 0;
        case (cshReq.cyc)
          mbxPkg::cycWriteback: expAcks <= mbxPkg::mbWords;
          mbxPkg::cycOneWordWr: expAcks <= 1;
          mbxPkg::cycCoreRead: begin
            expAcks   <= popCount(~cshReq.wordVal);
            expRdMask <= ~cshReq.wordVal;
          end
          mbxPkg::cycOneWordRd: begin
            expAcks   <= 1;
            expRdMask <= mbxPkg::wordMask_t'(1) << cshReq.wordAdr;
          end
          default: expAcks <= 0;
        endcase
      end else begin
        if (age != 0 && age < ageMax) begin
          age <= age + 1;
        end
        if (memAck) begin
          ackCnt    <= ackCnt + 1;
          expRdMask <= expRdMask & (expRdMask - 4'd1);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  idleAtStart: assert property (@(posedge clk) disable iff (!rstN)
    !seenStart |-> !busy && !mem.wrRq && !mem.rdRq)
    else flagError("busy or a request before the first start");
  wbWordIdx: assert property (@(posedge clk) disable iff (!rstN)
    curCyc == mbxPkg::cycWriteback && age >= 1 && age <= 4 |-> cacheWordIdx == wbIdx)
    else flagError("writeback cache word index out of step");
  owWordIdx: assert property (@(posedge clk) disable iff (!rstN)
    curCyc == mbxPkg::cycOneWordWr && age == 1 |-> cacheWordIdx == curAdr)
    else flagError("one-word write reads the wrong cache word");
  wrRise: assert property (@(posedge clk) disable iff (!rstN)
    (curCyc == mbxPkg::cycWriteback || curCyc == mbxPkg::cycOneWordWr) && age == 2
    |-> mem.wrRq)
    else flagError("write request not raised two cycles after start");
  wrLevel: assert property (@(posedge clk) disable iff (!rstN)
    mem.wrRq == (|expWrPend))
    else flagError("write request does not match pending words");
  wrWord: assert property (@(posedge clk) disable iff (!rstN)
    memAck && mem.wrRq |-> mem.wordSel == firstSet(expWrPend) &&
                           mem.data == line[firstSet(expWrPend)])
    else flagError("acknowledged write word or data wrong");
  wbOrder: assert property (@(posedge clk) disable iff (!rstN)
    memAck && mem.wrRq && curCyc == mbxPkg::cycWriteback |-> mem.wordSel == ackIdx)
    else flagError("writeback words retired out of order");
  holdWord: assert property (@(posedge clk) disable iff (!rstN)
    $past((mem.wrRq || mem.rdRq) && !memAck)
    |-> $stable(mem.wordSel) && $stable(mem.data) && $stable(mem.rqMask))
    else flagError("offered word changed before its acknowledge");
  rdLevel: assert property (@(posedge clk) disable iff (!rstN)
    mem.rqMask == expRdMask && mem.rdRq == (|expRdMask))
    else flagError("read mask or read request wrong");
  rdWord: assert property (@(posedge clk) disable iff (!rstN)
    mem.rdRq |-> mem.wordSel == firstSet(expRdMask) &&
                 (curCyc != mbxPkg::cycOneWordRd || mem.wordSel == curAdr))
    else flagError("read word select wrong");
  allValid: assert property (@(posedge clk) disable iff (!rstN)
    curCyc == mbxPkg::cycCoreRead && curVal == 4'hF && age >= 1 |-> !busy)
    else flagError("busy after a core read of an all-valid line");
  busyIdle: assert property (@(posedge clk) disable iff (!rstN)
    !busy |-> !(|expWrPend) && !(|expRdMask))
    else flagError("busy low while work is outstanding");
  busyDone: assert property (@(posedge clk) disable iff (!rstN)
    age >= 5 && !(|expWrPend) && !(|expRdMask) |-> !busy)
    else flagError("busy high with no outstanding work");
  ackTotal: assert property (@(posedge clk) disable iff (!rstN)
    $fell(busy) |-> ackCnt == expAcks)
    else flagError("wrong number of acknowledges for the operation");

  //////////////////////////////////////////////////
  // Memory acknowledge
  //////////////////////////////////////////////////
  initial begin
    memAck = 1'b0;
    ackWait = 0;
    ackRng = xorshift(rngSeed);
    forever begin
      @(posedge clk);
      #(driveDly);
      if (memAck) begin
        memAck = 1'b0;
        ackRng = xorshift(ackRng);
        ackWait = int'(ackRng[1:0]);
      end else if (mem.wrRq || mem.rdRq) begin
        if (ackWait == 0) begin
          memAck = 1'b1;
        end else begin
          ackWait--;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  task automatic runOp(input int opNum);
    int kind;
    logic [31:0] hi;
    stimRng = xorshift(stimRng);
    kind = (opNum < 8) ? opNum % 4 : int'(stimRng[1:0]);
    for (int k = 0; k < mbxPkg::mbWords; k++) begin
      stimRng = xorshift(stimRng);
      hi = stimRng;
      stimRng = xorshift(stimRng);
      line[k] = {hi[3:0], stimRng};
    end
    stimRng = xorshift(stimRng);
    case (kind)
      0: cshReq.cyc = mbxPkg::cycWriteback;
      1: cshReq.cyc = mbxPkg::cycOneWordWr;
      2: cshReq.cyc = mbxPkg::cycCoreRead;
      default: cshReq.cyc = mbxPkg::cycOneWordRd;
    endcase
    cshReq.wordAdr = stimRng[1:0];
    // One core read with the whole line valid
    cshReq.wordVal = (opNum == 6) ? 4'hF : stimRng[5:2];
    cshReq.start = 1'b1;
    @(posedge clk);
    #(driveDly);
    cshReq.start = 1'b0;
    while (busy) begin
      @(posedge clk);
      #(driveDly);
    end
  endtask

  initial begin
    rstN = 1'b0;
    cshReq = '0;
    stimRng = rngSeed;
    for (int k = 0; k < mbxPkg::mbWords; k++) begin
      line[k] = '0;
    end
    repeat (resetCycles) @(posedge clk);
    #(driveDly);
    rstN = 1'b1;
    repeat (3) @(posedge clk);
    #(driveDly);
    for (int i = 0; i < nOps; i++) begin
      runOp(i);
    end
    repeat (2) @(posedge clk);
    $display("Done: %0d operations, %0d acknowledges, %0d errors", nOps, totalAcks, errCnt);
    if (errCnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((resetCycles + 4 + nOps * opCycles) * periodNs);
    $display("TIMEOUT: the operations did not finish in the allowed time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: mbx.f
hdl/mbxPkg.sv
hdl/cacheToMbSeq.sv
hdl/mbWordTracker.sv
hdl/memReqCtl.sv
hdl/mbx.sv
tb/tbClock.sv
tb/mbxTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module mbxTb -f mbx.f -o mbxSim &&
  { out="$(./obj_dir/mbxSim)"; printf '%s\n' "$out"; } &&
  printf '%s\n' "$out" | grep -qxF '*** PASSED ***' &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
